// File: rtl/ifu_pkg.sv
package ifu_pkg;

  // data and address width
  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;

  // major opcodes, inst[6:0]
  parameter logic [6:0] OPC_JAL    = 7'b1101111;
  parameter logic [6:0] OPC_JALR   = 7'b1100111;
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_SYSTEM = 7'b1110011;
  parameter logic [6:0] OPC_LOAD   = 7'b0000011;

  // fence.i with rd, rs1 and imm all zero
  parameter word_t INST_FENCE_I = 32'h0000_100f;

  // refill bus sequence, one request per word
  typedef enum logic [2:0] {
    RF_IDLE,
    RF_REQ0,
    RF_GAP,
    RF_REQ1,
    RF_DONE
  } refill_state_e;

endpackage

// File: rtl/l1i_if.sv
`timescale 1ns/100ps

interface l1i_if #(
  parameter int L1I_IDX_W = 2
);
  import ifu_pkg::*;

  localparam int TAG_W = XLEN - L1I_IDX_W - 3;

  // fill side
  logic             fill_en;
  logic             fill_word;
  word_t            fill_data;
  logic [TAG_W-1:0] fill_tag;

  // lookup side
  logic             hit;
  word_t            rdata;

  modport refill (
    output fill_en,
    output fill_word,
    output fill_data,
    output fill_tag
  );

  modport lookup (
    input hit,
    input rdata
  );

endinterface

// File: rtl/l1i_refill.sv
`timescale 1ns/100ps

module l1i_refill #(
  parameter int L1I_IDX_W = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           miss_i,
  input  ifu_pkg::addr_t pc_i,
  output logic           arvalid_o,
  output logic           required_o,
  output ifu_pkg::addr_t araddr_o,
  input  logic           rvalid_i,
  input  ifu_pkg::word_t rdata_i,
  l1i_if.refill          fill [2**L1I_IDX_W]
);
  import ifu_pkg::*;

  localparam int N_LINES = 2 ** L1I_IDX_W;
  localparam int TAG_W = XLEN - L1I_IDX_W - 3;

  refill_state_e        state_q;
  refill_state_e        state_d;
  addr_t                line_addr_q;
  logic [L1I_IDX_W-1:0] line_idx;
  logic [TAG_W-1:0]     line_tag;
  logic                 beat;

  // line address is latched so a redirect cannot move an open request
  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && miss_i) begin
      line_addr_q <= {pc_i[XLEN-1:3], 3'b000};
    end
  end

  assign line_idx = line_addr_q[L1I_IDX_W+2:3];
  assign line_tag = line_addr_q[XLEN-1:L1I_IDX_W+3];

  assign arvalid_o  = (state_q == RF_REQ0) || (state_q == RF_REQ1);
  assign required_o = (state_q != RF_IDLE);
  assign araddr_o   = {line_addr_q[XLEN-1:3], state_q == RF_REQ1, 2'b00};
  assign beat       = arvalid_o && rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: if (miss_i) state_d = RF_REQ0;
      RF_REQ0: if (rvalid_i) state_d = RF_GAP;
      RF_GAP:  state_d = RF_REQ1;
      RF_REQ1: if (rvalid_i) state_d = RF_DONE;
      RF_DONE: state_d = RF_IDLE;
      default: state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // each beat goes to the indexed line only
  for (genvar g = 0; g < N_LINES; g++) begin : g_fill
    assign fill[g].fill_en   = beat && (line_idx == L1I_IDX_W'(g));
    assign fill[g].fill_word = (state_q == RF_REQ1);
    assign fill[g].fill_data = rdata_i;
    assign fill[g].fill_tag  = line_tag;
  end

  // request address holds until the data beat
  a_araddr_stable : assert property (
    @(posedge clk) disable iff (rst)
    arvalid_o && !rvalid_i |=> arvalid_o && $stable(araddr_o)
  );

endmodule

// File: rtl/l1i_line.sv
`timescale 1ns/100ps

module l1i_line #(
  parameter int L1I_IDX_W = 2,
  localparam int TAG_W = ifu_pkg::XLEN - L1I_IDX_W - 3
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic             word_sel_i,
  l1i_if                   port
);
  import ifu_pkg::*;

  word_t            data_q [2];
  logic [TAG_W-1:0] tag_q;
  logic             valid_q;

  always_ff @(posedge clk) begin
    if (port.fill_en) begin
      data_q[port.fill_word] <= port.fill_data;
      tag_q <= port.fill_tag;
    end
  end

  // word 0 opens the refill, word 1 completes it
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (port.fill_en) begin
      valid_q <= port.fill_word;
    end
  end

  assign port.hit   = valid_q && (tag_q == tag_i);
  assign port.rdata = data_q[word_sel_i];

  // a fence.i must not race the end of a refill
  a_no_fill_on_flush : assert property (
    @(posedge clk) disable iff (rst)
    !(port.fill_en && port.fill_word && flush_i)
  );

endmodule

// File: rtl/ifu_fetch_ctrl.sv
`timescale 1ns/100ps

module ifu_fetch_ctrl #(
  parameter int L1I_IDX_W = 2,
  parameter ifu_pkg::addr_t PC_INIT = 32'h8000_0000,
  localparam int TAG_W = ifu_pkg::XLEN - L1I_IDX_W - 3
) (
  input  logic             clk,
  input  logic             rst,
  l1i_if.lookup            line [2**L1I_IDX_W],
  output logic [TAG_W-1:0] tag_o,
  output logic             word_sel_o,
  output logic             flush_o,
  output logic             miss_o,
  output ifu_pkg::addr_t   pc_o,
  output ifu_pkg::word_t   inst_o,
  output logic             valid_o,
  output logic             ready_o,
  input  logic             next_ready_i,
  input  logic             prev_valid_i,
  input  logic             pc_change_i,
  input  logic             pc_retire_i,
  input  ifu_pkg::addr_t   npc_i,
  output logic             speculation_o,
  output logic             bad_speculation_o
);
  import ifu_pkg::*;

  localparam int N_LINES = 2 ** L1I_IDX_W;

  addr_t                pc_q;
  logic                 stall_q;
  logic                 spec_q;
  addr_t                spec_pc_q;
  addr_t                btb_q;
  logic                 btb_valid_q;
  logic [L1I_IDX_W-1:0] idx;
  logic [N_LINES-1:0]   hit_vec;
  word_t                rdata_arr [N_LINES];
  logic                 hit;
  logic                 accept;
  logic                 resolve;
  logic                 good_spec;
  logic                 is_branch;
  logic                 is_load;

  assign idx        = pc_q[L1I_IDX_W+2:3];
  assign tag_o      = pc_q[XLEN-1:L1I_IDX_W+3];
  assign word_sel_o = pc_q[2];

  // interface arrays only take constant indices
  for (genvar g = 0; g < N_LINES; g++) begin : g_lookup
    assign hit_vec[g]   = line[g].hit;
    assign rdata_arr[g] = line[g].rdata;
  end

  assign hit     = hit_vec[idx];
  assign inst_o  = rdata_arr[idx];
  assign miss_o  = !hit;
  assign valid_o = hit && !stall_q;
  assign ready_o = !valid_o;
  assign pc_o    = pc_q;
  assign accept  = valid_o && next_ready_i;

  // system counts as a branch, it may trap
  assign is_branch = (inst_o[6:0] == OPC_JAL) || (inst_o[6:0] == OPC_JALR) ||
                     (inst_o[6:0] == OPC_BRANCH) || (inst_o[6:0] == OPC_SYSTEM);
  assign is_load   = (inst_o[6:0] == OPC_LOAD);
  assign flush_o   = accept && (inst_o == INST_FENCE_I);

  assign resolve           = prev_valid_i && (pc_change_i || pc_retire_i);
  assign good_spec         = resolve && spec_q && (npc_i == spec_pc_q);
  assign bad_speculation_o = resolve && spec_q && (npc_i != spec_pc_q);
  assign speculation_o     = spec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= PC_INIT;
      stall_q     <= 1'b0;
      spec_q      <= 1'b0;
      btb_valid_q <= 1'b0;
    end else begin
      if (bad_speculation_o) begin
        pc_q    <= npc_i;
        stall_q <= 1'b0;
        spec_q  <= 1'b0;
      end else begin
        if (good_spec) begin
          spec_q <= 1'b0;
        end
        // a resolve during speculation belongs to the guessed branch
        if (resolve && stall_q && !spec_q) begin
          pc_q    <= npc_i;
          stall_q <= 1'b0;
        end else if (accept) begin
          if (is_load) begin
            stall_q <= 1'b1;
          end else if (is_branch && btb_valid_q && !spec_q) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else if (is_branch) begin
            stall_q <= 1'b1;
          end else begin
            pc_q <= pc_q + 32'd4;
          end
        end
      end
      if (prev_valid_i && pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prev_valid_i && pc_change_i) begin
      btb_q <= npc_i;
    end
    if (accept && is_branch && btb_valid_q && !spec_q && !bad_speculation_o) begin
      spec_pc_q <= btb_q;
    end
  end

  // one guess at a time, kept until the backend resolves it
  a_single_spec : assert property (
    @(posedge clk) disable iff (rst)
    spec_q && !resolve |=> spec_q && $stable(spec_pc_q)
  );

endmodule

// File: rtl/ifu_top.sv
`timescale 1ns/100ps

module ifu_top #(
  parameter int L1I_IDX_W = 2,
  parameter ifu_pkg::addr_t PC_INIT = 32'h8000_0000
) (
  input  logic           clk,
  input  logic           rst,
  output ifu_pkg::addr_t araddr_o,
  output logic           arvalid_o,
  output logic           required_o,
  input  ifu_pkg::word_t rdata_i,
  input  logic           rvalid_i,
  input  ifu_pkg::addr_t npc_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::addr_t pc_o,
  input  logic           pc_change_i,
  input  logic           pc_retire_i,
  output logic           speculation_o,
  output logic           bad_speculation_o,
  input  logic           prev_valid_i,
  input  logic           next_ready_i,
  output logic           valid_o,
  output logic           ready_o
);
  import ifu_pkg::*;

  localparam int N_LINES = 2 ** L1I_IDX_W;
  localparam int TAG_W = XLEN - L1I_IDX_W - 3;

  logic [TAG_W-1:0] lookup_tag;
  logic             word_sel;
  logic             flush;
  logic             miss;

  l1i_if #(.L1I_IDX_W(L1I_IDX_W)) line_if [N_LINES] ();

  l1i_refill #(
    .L1I_IDX_W (L1I_IDX_W)
  ) u_refill (
    .clk        (clk),
    .rst        (rst),
    .miss_i     (miss),
    .pc_i       (pc_o),
    .arvalid_o  (arvalid_o),
    .required_o (required_o),
    .araddr_o   (araddr_o),
    .rvalid_i   (rvalid_i),
    .rdata_i    (rdata_i),
    .fill       (line_if)
  );

  for (genvar g = 0; g < N_LINES; g++) begin : g_line
    l1i_line #(
      .L1I_IDX_W (L1I_IDX_W)
    ) u_line (
      .clk        (clk),
      .rst        (rst),
      .flush_i    (flush),
      .tag_i      (lookup_tag),
      .word_sel_i (word_sel),
      .port       (line_if[g])
    );
  end

  ifu_fetch_ctrl #(
    .L1I_IDX_W (L1I_IDX_W),
    .PC_INIT   (PC_INIT)
  ) u_fetch_ctrl (
    .clk               (clk),
    .rst               (rst),
    .line              (line_if),
    .tag_o             (lookup_tag),
    .word_sel_o        (word_sel),
    .flush_o           (flush),
    .miss_o            (miss),
    .pc_o              (pc_o),
    .inst_o            (inst_o),
    .valid_o           (valid_o),
    .ready_o           (ready_o),
    .next_ready_i      (next_ready_i),
    .prev_valid_i      (prev_valid_i),
    .pc_change_i       (pc_change_i),
    .pc_retire_i       (pc_retire_i),
    .npc_i             (npc_i),
    .speculation_o     (speculation_o),
    .bad_speculation_o (bad_speculation_o)
  );

endmodule

// File: verif/ifu_mem_model.sv
`timescale 1ns/100ps

module ifu_mem_model #(
  parameter int LATENCY = 3
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           arvalid_i,
  input  ifu_pkg::addr_t araddr_i,
  output logic           rvalid_o,
  output ifu_pkg::word_t rdata_o
);
  import ifu_pkg::*;

  addr_t patch_addr [$];
  word_t patch_data [$];
  logic  rvalid_q = 1'b0;
  word_t rdata_q = '0;
  logic  busy;
  addr_t req_addr;
  int    wait_cnt;

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // addi x1, x0, imm with the whole address folded into imm
  function automatic word_t word_at(addr_t addr);
    word_t       w;
    logic [11:0] imm;
    imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
    w = {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    foreach (patch_addr[i]) begin
      if (patch_addr[i] == addr) begin
        w = patch_data[i];
      end
    end
    return w;
  endfunction

  task automatic write_word(addr_t addr, word_t data);
    patch_addr.push_back(addr);
    patch_data.push_back(data);
  endtask

  // one read at a time, data comes back LATENCY cycles after the request
  always @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (busy) begin
        if (wait_cnt == 0) begin
          rvalid_q <= 1'b1;
          rdata_q  <= word_at(req_addr);
          busy     <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end else if (arvalid_i && !rvalid_q) begin
        busy     <= 1'b1;
        req_addr <= araddr_i;
        wait_cnt <= LATENCY - 1;
      end
    end
  end

endmodule

// File: verif/tb_ifu_top.sv
`timescale 1ns/100ps

module tb_ifu_top;
  import ifu_pkg::*;

  localparam addr_t PC_INIT      = 32'h8000_0000;
  localparam addr_t TGT1         = 32'h8000_1000;
  localparam addr_t TGT2         = 32'h8000_2000;
  localparam addr_t TGT3         = 32'h8000_3000;
  localparam word_t INST_LW      = 32'h0000_a283;
  localparam word_t INST_BEQ     = 32'h0000_0063;
  localparam word_t INST_NEW     = 32'h7ff0_0113;
  localparam int    N_TESTS      = 5;
  localparam int    CYCLE_BUDGET = 400;

  logic  clk;
  logic  rst;
  addr_t araddr;
  logic  arvalid;
  logic  required;
  word_t rdata;
  logic  rvalid;
  addr_t npc;
  word_t inst;
  addr_t pc;
  logic  pc_change;
  logic  pc_retire;
  logic  speculation;
  logic  bad_speculation;
  logic  prev_valid;
  logic  next_ready = 1'b0;
  logic  valid;
  logic  ready;

  int    seed = 32'h7a98_b4c2;
  int    errors;
  int    failed_tests;
  int    err_base;
  string cur_test;
  logic  gaps;
  logic  hold;
  addr_t exp_pc;
  addr_t req_log [$];

  ifu_top #(
    .L1I_IDX_W (2),
    .PC_INIT   (PC_INIT)
  ) i_ifu_top (
    .clk               (clk),
    .rst               (rst),
    .araddr_o          (araddr),
    .arvalid_o         (arvalid),
    .required_o        (required),
    .rdata_i           (rdata),
    .rvalid_i          (rvalid),
    .npc_i             (npc),
    .inst_o            (inst),
    .pc_o              (pc),
    .pc_change_i       (pc_change),
    .pc_retire_i       (pc_retire),
    .speculation_o     (speculation),
    .bad_speculation_o (bad_speculation),
    .prev_valid_i      (prev_valid),
    .next_ready_i      (next_ready),
    .valid_o           (valid),
    .ready_o           (ready)
  );

  ifu_mem_model #(
    .LATENCY (3)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (arvalid),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // decode side, random gaps only while gaps is set
  always @(posedge clk) begin
    next_ready <= !hold && (!gaps || ($random(seed) % 2 != 0));
  end

  // bus reads as the DUT sees them complete
  always @(posedge clk) begin
    if (arvalid && rvalid) begin
      req_log.push_back(araddr);
    end
  end

  initial begin
    repeat (N_TESTS * CYCLE_BUDGET) @(posedge clk);
    $display("watchdog expired after %0d cycles", N_TESTS * CYCLE_BUDGET);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
    $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic start_test(string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic end_test();
    if (errors == err_base) begin
      $display("test %s passed", cur_test);
    end else begin
      $display("test %s failed with %0d errors", cur_test, errors - err_base);
      failed_tests++;
    end
  endtask

  // outputs are sampled at the falling edge, accept happens on the next rise
  task automatic wait_accept(output addr_t got_pc, output word_t got_inst);
    int    n;
    logic  held;
    addr_t held_pc;
    word_t held_inst;
    n = 0;
    held = 1'b0;
    got_pc = '0;
    got_inst = '0;
    forever begin
      @(negedge clk);
      if (ready !== ~valid) begin
        $display("%s: ready_o is not the inverse of valid_o", cur_test);
        errors++;
      end
      if (held && (!valid || pc !== held_pc || inst !== held_inst)) begin
        $display("%s: instruction changed while next_ready_i was low", cur_test);
        errors++;
      end
      if (valid && next_ready) begin
        got_pc = pc;
        got_inst = inst;
        return;
      end
      held = valid && !next_ready;
      held_pc = pc;
      held_inst = inst;
      n++;
      if (n == 200) begin
        $display("%s: no instruction accepted within 200 cycles", cur_test);
        errors++;
        return;
      end
    end
  endtask

  task automatic fetch_check(addr_t want_pc);
    addr_t got_pc;
    word_t got_inst;
    word_t want_inst;
    want_inst = u_mem.word_at(want_pc);
    wait_accept(got_pc, got_inst);
    if (got_pc !== want_pc) report_mismatch("pc_o", want_pc, got_pc);
    if (got_inst !== want_inst) report_mismatch("inst_o", want_inst, got_inst);
    exp_pc = want_pc + 4;
  endtask

  task automatic check_stalled(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (valid !== 1'b0) begin
        $display("%s: valid_o rose before the backend resolved", cur_test);
        errors++;
      end
    end
  endtask

  // one cycle backend pulse, decode held off meanwhile
  task automatic resolve(logic change, addr_t target, output logic bad);
    hold = 1'b1;
    @(posedge clk);
    prev_valid <= 1'b1;
    pc_change  <= change;
    pc_retire  <= !change;
    npc        <= target;
    @(negedge clk);
    bad = bad_speculation;
    hold = 1'b0;
    @(posedge clk);
    prev_valid <= 1'b0;
    pc_change  <= 1'b0;
    pc_retire  <= 1'b0;
  endtask

  task automatic check_refill(addr_t base);
    if (req_log.size() != 2) begin
      $display("%s: %0d bus reads for line %h instead of 2", cur_test, req_log.size(), base);
      errors++;
    end else begin
      if (req_log[0] !== base) report_mismatch("araddr_o word 0", base, req_log[0]);
      if (req_log[1] !== base + 4) report_mismatch("araddr_o word 1", base + 4, req_log[1]);
    end
  endtask

  task automatic test_seq_fetch();
    start_test("seq_fetch");
    @(negedge clk);
    if ({arvalid, required, valid, speculation, bad_speculation} !== 5'b0) begin
      $display("%s: outputs not idle after reset", cur_test);
      errors++;
    end
    exp_pc = PC_INIT;
    repeat (6) fetch_check(exp_pc);
    end_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    gaps = 1'b1;
    repeat (12) fetch_check(exp_pc);
    gaps = 1'b0;
    end_test();
  endtask

  task automatic test_stalls();
    addr_t ld_pc;
    logic  bad;
    start_test("load_branch_stall");
    ld_pc = exp_pc + 8;
    u_mem.write_word(ld_pc, INST_LW);
    u_mem.write_word(TGT1, INST_BEQ);
    fetch_check(exp_pc);
    fetch_check(exp_pc);
    fetch_check(ld_pc);
    check_stalled(6);
    resolve(1'b0, TGT1, bad);
    if (bad !== 1'b0) report_mismatch("bad_speculation_o", 0, bad);
    fetch_check(TGT1);
    check_stalled(6);
    // no BTB entry yet, this resolve fills it
    resolve(1'b1, TGT2, bad);
    if (bad !== 1'b0) report_mismatch("bad_speculation_o", 0, bad);
    fetch_check(TGT2);
    end_test();
  endtask

  task automatic test_speculation();
    addr_t br_pc;
    logic  bad;
    start_test("speculation");
    br_pc = exp_pc + 8;
    u_mem.write_word(br_pc, INST_BEQ);
    fetch_check(exp_pc);
    fetch_check(exp_pc);
    fetch_check(br_pc);
    fetch_check(TGT2);
    if (speculation !== 1'b1) report_mismatch("speculation_o", 1, speculation);
    resolve(1'b1, TGT2, bad);
    if (bad !== 1'b0) report_mismatch("bad_speculation_o", 0, bad);
    fetch_check(TGT2 + 4);
    if (speculation !== 1'b0) report_mismatch("speculation_o", 0, speculation);
    fetch_check(exp_pc);
    fetch_check(br_pc);
    fetch_check(TGT2);
    // wrong guess this time
    resolve(1'b1, TGT3, bad);
    if (bad !== 1'b1) report_mismatch("bad_speculation_o", 1, bad);
    fetch_check(TGT3);
    end_test();
  endtask

  task automatic test_fence();
    addr_t f_pc;
    logic  bad;
    start_test("refill_fence_i");
    f_pc = exp_pc + 4;
    u_mem.write_word(f_pc + 4, INST_FENCE_I);
    u_mem.write_word(f_pc + 8, INST_BEQ);
    fetch_check(exp_pc);
    req_log.delete();
    fetch_check(f_pc);
    check_refill(f_pc);
    fetch_check(f_pc + 4);
    if (req_log.size() != 2) begin
      $display("%s: second word of the line went to the bus", cur_test);
      errors++;
    end
    @(posedge clk);
    u_mem.write_word(TGT3, INST_NEW);
    // BTB still points at TGT3, which was cached before the fence
    fetch_check(f_pc + 8);
    req_log.delete();
    fetch_check(TGT3);
    check_refill(TGT3);
    resolve(1'b1, TGT3, bad);
    if (bad !== 1'b0) report_mismatch("bad_speculation_o", 0, bad);
    end_test();
  endtask

  initial begin
    rst          = 1'b1;
    prev_valid   = 1'b0;
    pc_change    = 1'b0;
    pc_retire    = 1'b0;
    npc          = '0;
    gaps         = 1'b0;
    hold         = 1'b0;
    errors       = 0;
    failed_tests = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_seq_fetch();
    test_backpressure();
    test_stalls();
    test_speculation();
    test_fence();
    $display("tests run: %0d, tests failed: %0d, errors: %0d", N_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: compile.f
rtl/ifu_pkg.sv
rtl/l1i_if.sv
rtl/l1i_refill.sv
rtl/l1i_line.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_top.sv
verif/ifu_mem_model.sv
verif/tb_ifu_top.sv
